//--- build.f
source/ppu_pkg.sv
source/ppu_stream_if.sv
source/sync_fifo.sv
source/ppu_coord_gen.sv
source/ppu_pixel_agu.sv
source/ppu_pixel_unpack.sv
source/ppu_blitter.sv
verification/ppu_blitter_tb.sv

//--- Bender.yml
package:
  name: ppu_blitter

sources:
  - source/ppu_pkg.sv
  - source/ppu_stream_if.sv
  - source/sync_fifo.sv
  - source/ppu_coord_gen.sv
  - source/ppu_pixel_agu.sv
  - source/ppu_pixel_unpack.sv
  - source/ppu_blitter.sv
  - target: test
    files:
      - verification/ppu_blitter_tb.sv

//--- verification/ppu_blitter_trace.txt
# S type mode texture_ptr texsize halfsize count u0 v0 (hex; type 0 FILL, 1 BLIT, 3 ABLIT)
# P pix_data transparent (hex; expected pixels of the span above, in order)
S 1 0 00010000 0 0 003 002 001
P 25c9 0
P 25c8 0
P 25cf 0
P 25ce 0
S 1 2 00002000 1 0 005 002 003
P 0005 0
P 000b 0
P 000e 0
P 000c 0
P 0005 0
P 000b 0
S 1 3 00003000 0 0 003 005 002
P 0000 0
P 0001 0
P 0001 0
P 0000 1
S 3 0 00005000 1 1 003 006 002
P 8dd5 0
P 8dd4 0
P 0000 1
P 0000 1
S 0 0 00000000 0 0 005 000 000
S 1 1 00006000 0 0 003 000 000
P 00c3 0
P 0095 0
P 00c2 0
P 0095 0

//--- verification/ppu_blitter_tb.sv
/*
 * Trace-driven testbench for the texture-fetch top level. Spans and expected
 * pixels come from the trace file, a memory model answers the bus reads and
 * random ready signals add back-pressure on the bus and the pixel output.
 */

module ppu_blitter_tb import ppu_pkg::*; ();

localparam string TRACE_FILE = "verification/ppu_blitter_trace.txt";

// One span command as read from the trace
typedef struct packed {
	span_type_t            stype;
	pixmode_t              mode;
	logic [W_ADDR-1:0]     ptr;
	logic [2:0]            texsize;
	logic                  half;
	logic [W_COORD_SX-1:0] count;
	logic [W_COORD_UV-1:0] u0;
	logic [W_COORD_UV-1:0] v0;
} span_rec_t;

logic                  clk = 1'b0;
logic                  rst_n;
logic                  span_start;
span_type_t            span_type;
pixmode_t              span_pixmode;
logic [W_ADDR-1:0]     span_texture_ptr;
logic [2:0]            span_texsize;
logic                  span_ablit_halfsize;
logic [W_COORD_SX-1:0] span_count;
logic [W_COORD_UV-1:0] span_u0;
logic [W_COORD_UV-1:0] span_v0;
logic                  span_done;
logic                  bus_addr_vld;
logic                  bus_addr_rdy;
logic [W_ADDR-1:0]     bus_addr;
logic [1:0]            bus_size;
logic [15:0]           bus_rdata;
logic                  bus_rdata_vld;
logic [15:0]           pix_data;
logic                  pix_transparent;
logic                  pix_vld;
logic                  pix_rdy;

// Trace contents
span_rec_t         spans[$];
int                span_npix[$];
logic [15:0]       exp_data[$];
logic              exp_transp[$];

// Reads in flight for the memory model with their return cycle
logic [W_ADDR-1:0] pend_addr[$];
int                pend_due[$];
int                last_due = 0;

span_rec_t         cur_span;
int                rd_idx = 0;
int                cycle = 0;
int                limit = 0;
int                errors = 0;
int                reads = 0;
int                pixels = 0;
int                consumed = 0;

ppu_blitter ppu_blitter_i (.*);

initial begin
	forever #50 clk = ~clk;
end

// ------------------------------
// Reference model of the address rule

function automatic int pix_bits(input pixmode_t mode);
	case (mode)
		MODE_ARGB1555: return 16;
		MODE_PAL8:     return 8;
		MODE_PAL4:     return 4;
		default:       return 1;
	endcase
endfunction

// Halfsize ABLIT halves the side
function automatic int side_of(input span_rec_t s);
	int tsz;
	tsz = int'(s.texsize);
	if (s.stype == SPANTYPE_ABLIT && s.half)
		tsz = tsz - 1;
	return 1 << (tsz + 3);
endfunction

function automatic logic in_bounds(input span_rec_t s, input int idx);
	int side;
	side = side_of(s);
	return (int'(s.u0) + idx) < side && int'(s.v0) < side;
endfunction

function automatic logic [W_ADDR-1:0] expected_addr(input span_rec_t s, input int idx);
	longint unsigned pix_index;
	longint unsigned byte_offs;
	logic [W_ADDR-1:0] addr;
	pix_index = longint'(s.u0) + idx + longint'(s.v0) * side_of(s);
	byte_offs = pix_index * pix_bits(s.mode) / 8;
	addr      = s.ptr + W_ADDR'(byte_offs);
	// Halfword aligned
	addr[0]   = 1'b0;
	return addr;
endfunction

// In-bounds pixels of the span not yet read
function automatic int reads_left(input span_rec_t s, input int from);
	int n;
	n = 0;
	for (int i = from; i <= int'(s.count); i++)
		if (in_bounds(s, i))
			n++;
	return n;
endfunction

// ------------------------------
// Checks

task automatic check_addr(input logic [W_ADDR-1:0] got, input logic [W_ADDR-1:0] exp);
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: bus_addr %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_size(input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: bus_size %h, expected %h", $time, got, exp);
	end
endtask

task automatic check_pixel(input logic [15:0] got_data, input logic got_transp);
	logic [15:0] exp_d;
	logic        exp_t;
	if (exp_data.size() == 0) begin
		errors++;
		$display("Pixel %h arrived at %0t with no pixel left to expect", got_data, $time);
	end else begin
		exp_d = exp_data.pop_front();
		exp_t = exp_transp.pop_front();
		if (got_data !== exp_d || got_transp !== exp_t) begin
			errors++;
			$display("** Error at %0t: pixel %h transparent %b, expected %h transparent %b",
				$time, got_data, got_transp, exp_d, exp_t);
		end
	end
endtask

task automatic check_done(input logic got, input logic exp);
	if (got !== exp) begin
		errors++;
		$display("** Error at %0t: span_done %b, expected %b", $time, got, exp);
	end
endtask

// ------------------------------
// Trace and bus handling

task automatic read_trace();
	int        fd;
	int        n;
	int        f[8];
	string     line;
	span_rec_t s;
	fd = $fopen(TRACE_FILE, "r");
	if (fd == 0) begin
		errors++;
		$display("Cannot open trace file %s", TRACE_FILE);
	end else begin
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) == "S") begin
				n = $sscanf(line, "S %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
				if (n != 8) begin
					errors++;
					$display("Malformed span record in trace: %s", line);
				end
				s.stype   = span_type_t'(3'(f[0]));
				s.mode    = pixmode_t'(2'(f[1]));
				s.ptr     = W_ADDR'(f[2]);
				s.texsize = 3'(f[3]);
				s.half    = 1'(f[4]);
				s.count   = W_COORD_SX'(f[5]);
				s.u0      = W_COORD_UV'(f[6]);
				s.v0      = W_COORD_UV'(f[7]);
				spans.push_back(s);
				span_npix.push_back(0);
			end else if (line.len() > 0 && line.getc(0) == "P" && spans.size() > 0) begin
				n = $sscanf(line, "P %h %h", f[0], f[1]);
				if (n != 2) begin
					errors++;
					$display("Malformed pixel record in trace: %s", line);
				end
				exp_data.push_back(16'(f[0]));
				exp_transp.push_back(1'(f[1]));
				span_npix[span_npix.size()-1] += 1;
			end
		end
		$fclose(fd);
	end
endtask

// Accepted address is checked and queued for the memory model
task automatic take_read();
	int idx;
	int due;
	reads++;
	check_size(bus_size, BUS_SIZE_HALF);
	if (cur_span.stype == SPANTYPE_FILL) begin
		errors++;
		$display("Bus read at %0t during a FILL span", $time);
	end else begin
		idx = rd_idx;
		// Out-of-bounds pixels have no read
		while (idx <= int'(cur_span.count) && !in_bounds(cur_span, idx))
			idx++;
		if (idx > int'(cur_span.count)) begin
			errors++;
			$display("Bus read at %0t beyond the last pixel of the span", $time);
		end else begin
			check_addr(bus_addr, expected_addr(cur_span, idx));
			rd_idx = idx + 1;
		end
	end
	// Latency of 1 to 3 cycles with returns kept in order
	due = cycle + int'($urandom_range(1, 3));
	if (due <= last_due)
		due = last_due + 1;
	last_due = due;
	pend_addr.push_back(bus_addr);
	pend_due.push_back(due);
endtask

task automatic run_span(input span_rec_t s, input int npix);
	int target;
	target = pixels + npix;
	@(negedge clk);
	cur_span            = s;
	rd_idx              = 0;
	span_type           = s.stype;
	span_pixmode        = s.mode;
	span_texture_ptr    = s.ptr;
	span_texsize        = s.texsize;
	span_ablit_halfsize = s.half;
	span_count          = s.count;
	span_u0             = s.u0;
	span_v0             = s.v0;
	span_start          = 1'b1;
	@(negedge clk);
	span_start = 1'b0;
	if (s.stype == SPANTYPE_FILL) begin
		// Nothing to fetch, so done never drops
		check_done(span_done, 1'b1);
		repeat (4) @(negedge clk);
		check_done(span_done, 1'b1);
	end else begin
		check_done(span_done, 1'b0);
		while (pixels < target)
			@(negedge clk);
		while (!span_done)
			@(negedge clk);
		if (reads_left(s, rd_idx) != 0) begin
			errors++;
			$display("Span ended with %0d bus reads missing", reads_left(s, rd_idx));
		end
	end
endtask

// ------------------------------
// Monitor sampled on the rising edge

always @(posedge clk) begin
	if (cycle >= limit) begin
		$display("Timeout: run stopped after %0d cycles", cycle);
		$display("Errors: %0d, bus reads: %0d, pixels: %0d", errors, reads, pixels);
		$display("STATUS: FAIL");
		$finish;
	end else begin
		cycle++;
		if (bus_addr_vld && bus_addr_rdy)
			take_read();
		if (pix_vld && pix_rdy) begin
			check_pixel(pix_data, pix_transparent);
			pixels++;
			if (!pix_transparent)
				consumed++;
		end
		// Each read not yet turned into a pixel holds a credit
		if (reads - consumed > RDATA_DEPTH) begin
			errors++;
			$display("More than %0d bus reads outstanding at %0t", RDATA_DEPTH, $time);
		end
	end
end

// Back-pressure and memory model driven on the falling edge
always @(negedge clk) begin
	bus_addr_rdy = ($urandom % 4) != 0;
	pix_rdy      = ($urandom % 3) != 0;
	if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
		bus_rdata     = pend_addr[0][16:1] ^ 16'ha5c3;
		bus_rdata_vld = 1'b1;
		void'(pend_addr.pop_front());
		void'(pend_due.pop_front());
	end else begin
		bus_rdata     = 16'h0;
		bus_rdata_vld = 1'b0;
	end
end

// ------------------------------
// Main sequence

initial begin
	void'($urandom(32'h2efc_153f));
	rst_n               = 1'b0;
	span_start          = 1'b0;
	span_type           = SPANTYPE_FILL;
	span_pixmode        = MODE_ARGB1555;
	span_texture_ptr    = '0;
	span_texsize        = '0;
	span_ablit_halfsize = 1'b0;
	span_count          = '0;
	span_u0             = '0;
	span_v0             = '0;
	bus_addr_rdy        = 1'b0;
	bus_rdata           = 16'h0;
	bus_rdata_vld       = 1'b0;
	pix_rdy             = 1'b0;
	read_trace();
	limit = 40 * exp_data.size() + 200;
	repeat (5) @(negedge clk);
	rst_n = 1'b1;
	foreach (spans[i])
		run_span(spans[i], span_npix[i]);
	repeat (10) @(negedge clk);
	if (exp_data.size() != 0 || pend_addr.size() != 0) begin
		errors++;
		$display("Run ended with %0d pixels and %0d reads unfinished",
			exp_data.size(), pend_addr.size());
	end
	$display("Errors: %0d, spans: %0d, bus reads: %0d, pixels: %0d",
		errors, spans.size(), reads, pixels);
	if (errors == 0)
		$display("STATUS: PASS");
	else
		$display("STATUS: FAIL");
	$finish;
end

endmodule

//--- source/ppu_blitter.sv
/*
 * Texture-fetch top level. Coordinate walker, address unit and
 * unpacker joined by two streams, with plain ports outside.
 */

module ppu_blitter import ppu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	// Span command
	input  logic                  span_start,
	input  span_type_t            span_type,
	input  pixmode_t              span_pixmode,
	input  logic [W_ADDR-1:0]     span_texture_ptr,
	input  logic [2:0]            span_texsize,
	input  logic                  span_ablit_halfsize,
	input  logic [W_COORD_SX-1:0] span_count,
	input  logic [W_COORD_UV-1:0] span_u0,
	input  logic [W_COORD_UV-1:0] span_v0,
	output logic                  span_done,

	// Bus
	output logic                  bus_addr_vld,
	input  logic                  bus_addr_rdy,
	output logic [W_ADDR-1:0]     bus_addr,
	output logic [1:0]            bus_size,
	input  logic [15:0]           bus_rdata,
	input  logic                  bus_rdata_vld,

	// Pixel output
	output logic [15:0]           pix_data,
	output logic                  pix_transparent,
	output logic                  pix_vld,
	input  logic                  pix_rdy
);

logic rdata_credit;

ppu_stream_if #(.payload_t(coord_t)) coord_s ();
ppu_stream_if #(.payload_t(pinfo_t)) pinfo_s ();

ppu_coord_gen coord_gen_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.span_start (span_start),
	.span_type  (span_type),
	.span_count (span_count),
	.span_u0    (span_u0),
	.span_v0    (span_v0),
	.coord      (coord_s.source)
);

ppu_pixel_agu pixel_agu_i (
	.clk                 (clk),
	.rst_n               (rst_n),
	.span_start          (span_start),
	.span_type           (span_type),
	.span_pixmode        (span_pixmode),
	.span_texture_ptr    (span_texture_ptr),
	.span_texsize        (span_texsize),
	.span_ablit_halfsize (span_ablit_halfsize),
	.span_count          (span_count),
	.span_done           (span_done),
	.coord               (coord_s.sink),
	.bus_addr_vld        (bus_addr_vld),
	.bus_addr            (bus_addr),
	.bus_size            (bus_size),
	.bus_addr_rdy        (bus_addr_rdy),
	.rdata_credit        (rdata_credit),
	.pinfo               (pinfo_s.source)
);

ppu_pixel_unpack pixel_unpack_i (
	.clk             (clk),
	.rst_n           (rst_n),
	.bus_rdata       (bus_rdata),
	.bus_rdata_vld   (bus_rdata_vld),
	.rdata_credit    (rdata_credit),
	.pinfo           (pinfo_s.sink),
	.pix_data        (pix_data),
	.pix_transparent (pix_transparent),
	.pix_vld         (pix_vld),
	.pix_rdy         (pix_rdy)
);

endmodule

//--- source/ppu_pixel_unpack.sv
/*
 * Pairs returned halfwords with pixel metadata and extracts each pixel.
 * Returns one read credit per halfword popped.
 */

module ppu_pixel_unpack import ppu_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,

	// Bus data phase that cannot stall
	input  logic [15:0] bus_rdata,
	input  logic        bus_rdata_vld,
	output logic        rdata_credit,

	ppu_stream_if.sink  pinfo,

	output logic [15:0] pix_data,
	output logic        pix_transparent,
	output logic        pix_vld,
	input  logic        pix_rdy
);

logic [15:0] rdata_head;
logic        rdata_empty;
logic        rdata_pop;
logic        discard;
logic [2:0]  lps;
logic [3:0]  field_idx;
logic [3:0]  field_shift;
logic [15:0] field_mask;
logic [15:0] field;
logic        pix_xfer;

// ------------------------------
// Read-data buffer

// Credits keep this from overflowing
sync_fifo #(
	.payload_t (logic [15:0]),
	.DEPTH     (RDATA_DEPTH)
) rdata_fifo (
	.clk    (clk),
	.rst_n  (rst_n),
	.w_data (bus_rdata),
	.w_en   (bus_rdata_vld),
	.r_data (rdata_head),
	.r_en   (rdata_pop),
	.full   (),
	.empty  (rdata_empty)
);

// ------------------------------
// Field extraction

assign discard = pinfo.payload.discard;
assign lps     = log_pixsize(pinfo.payload.pixmode);

// Index wraps on the 16 >> lps fields per halfword
assign field_idx   = pinfo.payload.u_lo & 4'((16 >> lps) - 1);
assign field_shift = field_idx << lps;
// Width of 16 shifts everything out and leaves an all-ones mask
assign field_mask  = ~(16'hffff << (5'd1 << lps));
assign field       = (rdata_head >> field_shift) & field_mask;

// Discards have no data coming
assign pix_vld         = pinfo.vld && (discard || !rdata_empty);
assign pix_data        = discard ? 16'h0 : field;
assign pix_transparent = discard;

assign pix_xfer     = pix_vld && pix_rdy;
assign pinfo.rdy    = pix_xfer;
assign rdata_pop    = pix_xfer && !discard;
assign rdata_credit = rdata_pop;

endmodule

//--- source/ppu_pixel_agu.sv
/*
 * Pixel address generator. Turns coordinates into halfword bus reads,
 * discards out-of-bounds pixels, and queues per-pixel metadata.
 */

module ppu_pixel_agu import ppu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  span_start,
	input  span_type_t            span_type,
	input  pixmode_t              span_pixmode,
	input  logic [W_ADDR-1:0]     span_texture_ptr,
	input  logic [2:0]            span_texsize,
	input  logic                  span_ablit_halfsize,
	input  logic [W_COORD_SX-1:0] span_count,
	output logic                  span_done,

	ppu_stream_if.sink            coord,

	// Address phase only as read data returns at the unpacker
	output logic                  bus_addr_vld,
	output logic [W_ADDR-1:0]     bus_addr,
	output logic [1:0]            bus_size,
	input  logic                  bus_addr_rdy,
	input  logic                  rdata_credit,

	ppu_stream_if.source          pinfo
);

logic [W_COORD_SX-1:0] count;
pixmode_t              pixmode;
logic [W_ADDR-1:0]     texture_ptr;
logic [2:0]            texsize;
logic [W_CREDIT-1:0]   credits;

logic [W_COORD_UV-1:0] side_mask;
logic                  out_of_bounds;
logic [W_ADDR-1:0]     pix_index;
logic [W_ADDR-1:0]     byte_offs;
logic [W_ADDR-1:0]     addr_sum;
logic                  take_discard;
logic                  addr_xfer;
logic                  issue;
logic                  pinfo_full;
logic                  pinfo_empty;
pinfo_t                pinfo_wdata;

// ------------------------------
// Span state

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		span_done <= 1'b1;
		count     <= '0;
	end else if (span_start) begin
		span_done <= span_type == SPANTYPE_FILL;
		count     <= span_count;
	end else if (issue) begin
		count <= count - 1'b1;
		if (count == '0)
			span_done <= 1'b1;
	end
end

// Halfsize ABLIT shrinks the side by one power of two
always_ff @(posedge clk) begin
	if (span_start) begin
		pixmode     <= span_pixmode;
		texture_ptr <= span_texture_ptr;
		texsize     <= span_texsize - 3'(span_ablit_halfsize && span_type == SPANTYPE_ABLIT);
	end
end

// ------------------------------
// Address and bounds

// Mask keeps the ordinate bits below a side of 2 ** (texsize + 3)
assign side_mask     = ~({W_COORD_UV{1'b1}} << (texsize + 3));
assign out_of_bounds = |(coord.payload.u & ~side_mask) || |(coord.payload.v & ~side_mask);

assign pix_index = W_ADDR'(coord.payload.u) + (W_ADDR'(coord.payload.v) << (texsize + 3));
// Bit offset divided down to bytes
assign byte_offs = (pix_index << log_pixsize(pixmode)) >> 3;
assign addr_sum  = texture_ptr + byte_offs;

assign bus_addr = {addr_sum[W_ADDR-1:1], 1'b0};
assign bus_size = BUS_SIZE_HALF;

// Reads need a credit while discards need only metadata space
assign bus_addr_vld = !span_done && coord.vld && !out_of_bounds
	&& !pinfo_full && credits != '0;
assign take_discard = !span_done && coord.vld && out_of_bounds && !pinfo_full;

assign addr_xfer = bus_addr_vld && bus_addr_rdy;
assign issue     = addr_xfer || take_discard;
assign coord.rdy = issue;

// ------------------------------
// Read credits

// One credit out per address and one back per unpacker pop
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n)
		credits <= W_CREDIT'(RDATA_DEPTH);
	else
		credits <= credits - W_CREDIT'(addr_xfer) + W_CREDIT'(rdata_credit);
end

// ------------------------------
// Metadata FIFO

assign pinfo_wdata.discard = out_of_bounds;
assign pinfo_wdata.u_lo    = coord.payload.u[3:0];
assign pinfo_wdata.pixmode = pixmode;

sync_fifo #(
	.payload_t (pinfo_t),
	.DEPTH     (PINFO_DEPTH)
) pinfo_fifo (
	.clk    (clk),
	.rst_n  (rst_n),
	.w_data (pinfo_wdata),
	.w_en   (issue),
	.r_data (pinfo.payload),
	.r_en   (pinfo.vld && pinfo.rdy),
	.full   (pinfo_full),
	.empty  (pinfo_empty)
);

assign pinfo.vld = !pinfo_empty;

endmodule

//--- source/ppu_coord_gen.sv
/*
 * Texture coordinate walker for one span.
 * Presents u0 + i, v0 for i in 0..count, one step per transfer.
 */

module ppu_coord_gen import ppu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  span_start,
	input  span_type_t            span_type,
	input  logic [W_COORD_SX-1:0] span_count,
	input  logic [W_COORD_UV-1:0] span_u0,
	input  logic [W_COORD_UV-1:0] span_v0,

	ppu_stream_if.source          coord
);

logic [W_COORD_SX-1:0] remaining;
logic                  active;
coord_t                cur;
logic                  load;
logic                  xfer;

// FILL spans fetch nothing, so no coordinates
assign load = span_start && span_type != SPANTYPE_FILL;
assign xfer = coord.vld && coord.rdy;

assign coord.vld     = active;
assign coord.payload = cur;

// ------------------------------
// Span progress

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		active    <= 1'b0;
		remaining <= '0;
	end else if (load) begin
		active    <= 1'b1;
		remaining <= span_count;
	end else if (xfer) begin
		// Last pixel just went out
		if (remaining == '0)
			active <= 1'b0;
		else
			remaining <= remaining - 1'b1;
	end
end

// ------------------------------
// Coordinate register

// v stays put across the span, u steps by one
always_ff @(posedge clk) begin
	if (load) begin
		cur.u <= span_u0;
		cur.v <= span_v0;
	end else if (xfer) begin
		cur.u <= cur.u + 1'b1;
	end
end

endmodule

//--- source/sync_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO, payload of any type.
 * DEPTH must be a power of two. Head entry is visible on r_data.
 */

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n,

	input  payload_t w_data,
	input  logic     w_en,
	output payload_t r_data,
	input  logic     r_en,
	output logic     full,
	output logic     empty
);

// One index bit minimum so that DEPTH of 1 still builds
localparam int W_IDX = DEPTH > 1 ? $clog2(DEPTH) : 1;

payload_t       mem [2**W_IDX];
logic [W_IDX:0] wptr;
logic [W_IDX:0] rptr;
logic [W_IDX:0] level;
logic           push;
logic           pop;

// Extra pointer bit tells full from empty
assign level = wptr - rptr;
assign full  = level == (W_IDX + 1)'(DEPTH);
assign empty = level == '0;

// Ignore writes when full and reads when empty
assign push = w_en && !full;
assign pop  = r_en && !empty;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		wptr <= '0;
		rptr <= '0;
	end else begin
		if (push)
			wptr <= wptr + 1'b1;
		if (pop)
			rptr <= rptr + 1'b1;
	end
end

// Storage
always_ff @(posedge clk) begin
	if (push)
		mem[wptr[W_IDX-1:0]] <= w_data;
end

assign r_data = mem[rptr[W_IDX-1:0]];

endmodule

//--- source/ppu_stream_if.sv
/*
 * Valid/ready stream carrying one payload of any type.
 * Source drives payload and vld; sink drives rdy.
 */

interface ppu_stream_if #(
	parameter type payload_t = logic
) ();

payload_t payload;
logic     vld;
logic     rdy;

// Payload and vld hold from raise of vld until the transfer
modport source (
	output payload,
	output vld,
	input  rdy
);

modport sink (
	input  payload,
	input  vld,
	output rdy
);

endinterface

//--- source/ppu_pkg.sv
/*
 * Shared widths, depths and types for the texture-fetch path.
 * Imported by wildcard in each module header that needs it.
 */

package ppu_pkg;

// Bus and coordinate widths
localparam int W_ADDR      = 32;
localparam int W_COORD_UV  = 10;
localparam int W_COORD_SX  = 9;

// Read-data FIFO depth sets the number of read credits
localparam int RDATA_DEPTH = 4;
localparam int PINFO_DEPTH = 4;
localparam int W_CREDIT    = $clog2(RDATA_DEPTH + 1);

// Halfword transfer size code on the bus
localparam logic [1:0] BUS_SIZE_HALF = 2'h1;

typedef enum logic [2:0] {
	SPANTYPE_FILL  = 3'h0,
	SPANTYPE_BLIT  = 3'h1,
	SPANTYPE_ABLIT = 3'h3
} span_type_t;

typedef enum logic [1:0] {
	MODE_ARGB1555 = 2'h0,
	MODE_PAL8     = 2'h1,
	MODE_PAL4     = 2'h2,
	MODE_PAL1     = 2'h3
} pixmode_t;

// log2 of bits per pixel
function automatic logic [2:0] log_pixsize(input pixmode_t mode);
	case (mode)
		MODE_ARGB1555: return 3'd4;
		MODE_PAL8:     return 3'd3;
		MODE_PAL4:     return 3'd2;
		default:       return 3'd0;
	endcase
endfunction

typedef struct packed {
	logic [W_COORD_UV-1:0] u;
	logic [W_COORD_UV-1:0] v;
} coord_t;

// Per-pixel metadata that travels alongside the bus read
typedef struct packed {
	logic       discard;
	logic [3:0] u_lo;
	pixmode_t   pixmode;
} pinfo_t;

endpackage
